// File: tb.f
+incdir+common
common/core_pkg.sv
verilog/uop_decoder.sv
verilog/uop_queue.sv
execute/int_alu.sv
execute/int_execute.sv
verilog/exec_core.sv
bench/exec_core_asserts.sv
bench/exec_core_tb.sv

// File: Bender.yml
package:
  name: exec_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - verilog/uop_decoder.sv
      - verilog/uop_queue.sv
      - execute/int_alu.sv
      - execute/int_execute.sv
      - verilog/exec_core.sv
  - target: test
    files:
      - bench/exec_core_asserts.sv
      - bench/exec_core_tb.sv

// File: bench/exec_core_tb.sv
/* self-checking testbench for exec_core with expected writebacks worked out per entry
   strobes wait for busy low so no instruction is ever dropped */
`timescale 1ns/1ps

module exec_core_tb;

  typedef struct packed {
    logic [31:0] word;
    logic [63:0] data;
    logic [3:0]  flags;   // carry, overflow, negative, zero
    logic        skipped;
    logic        burst;   // no idle cycles before this strobe
  } entry_t;

  localparam logic [3:0] o_add  = 4'd0;
  localparam logic [3:0] o_sub  = 4'd1;
  localparam logic [3:0] o_and  = 4'd2;
  localparam logic [3:0] o_or   = 4'd3;
  localparam logic [3:0] o_xor  = 4'd4;
  localparam logic [3:0] o_shl  = 4'd5;
  localparam logic [3:0] o_shr  = 4'd6;
  localparam logic [3:0] o_sar  = 4'd7;
  localparam logic [3:0] o_movi = 4'd8;
  localparam logic [3:0] o_mul  = 4'd9;
  localparam logic [3:0] o_bad  = 4'd12;
  localparam logic [3:0] c_eq   = 4'd8;
  localparam logic [3:0] c_ne   = 4'd9;
  localparam logic [3:0] c_al   = 4'd11;
  localparam logic [3:0] c_lt   = 4'd14; // overflow xor negative
  localparam int busy_timeout   = 50;
  localparam int wb_timeout     = 100;
  localparam int quiet_cycles   = 40;

  logic          clk;
  logic          rst;
  logic          instr_valid;
  logic [31:0]   instr;
  logic          busy;
  logic          wb_valid;
  core_pkg::wb_t wb;

  entry_t      table_q[$];
  logic [31:0] rng_state = 32'h8cdc_5af3;
  int          wb_count = 0;
  int          busy_cycles = 0;

  exec_core dut0 (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  bind exec_core exec_core_asserts asrt0 (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .busy        (busy),
    .deq         (deq),
    .head        (head),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && wb_valid) wb_count++;
    if (!rst && busy) busy_cycles++;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  task automatic push_entry(input logic [31:0] word, input logic [63:0] data,
                            input logic [3:0] flags, input logic skipped, input logic burst);
    table_q.push_back({word, data, flags, skipped, burst});
  endtask

  // word = {op, cond, rt ra rb, imm}
  task automatic load_table();
    push_entry({o_movi, c_al, 12'h100, 12'h005}, 64'h5, 4'b0000, 1'b0, 1'b0);
    push_entry({o_movi, c_al, 12'h200, 12'hfff}, 64'hFFFF_FFFF_FFFF_FFFF, 4'b0010, 1'b0, 1'b0);
    push_entry({o_movi, c_al, 12'h300, 12'h7ff}, 64'h7FF, 4'b0000, 1'b0, 1'b0);
    push_entry({o_movi, c_al, 12'h400, 12'h800}, 64'hFFFF_FFFF_FFFF_F800, 4'b0010, 1'b0, 1'b0);
    push_entry({o_movi, c_al, 12'h500, 12'h000}, 64'h0, 4'b0001, 1'b0, 1'b0);
    push_entry({o_add, c_al, 12'h613, 12'h000}, 64'h804, 4'b0000, 1'b0, 1'b0);
    push_entry({o_add, c_al, 12'h721, 12'h000}, 64'h4, 4'b1000, 1'b0, 1'b0); // unsigned wrap
    push_entry({o_shr, c_al, 12'h820, 12'h001}, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0000, 1'b0, 1'b0);
    push_entry({o_add, c_al, 12'h980, 12'h001}, 64'h8000_0000_0000_0000, 4'b0110, 1'b0, 1'b0);
    push_entry({o_sub, c_al, 12'ha13, 12'h000}, 64'hFFFF_FFFF_FFFF_F806, 4'b0010, 1'b0, 1'b0);
    push_entry({o_sub, c_al, 12'hb31, 12'h000}, 64'h7FA, 4'b1000, 1'b0, 1'b0);
    push_entry({o_sub, c_al, 12'hc91, 12'h000}, 64'h7FFF_FFFF_FFFF_FFFB, 4'b1100, 1'b0, 1'b0);
    push_entry({o_sub, c_al, 12'hd11, 12'h000}, 64'h0, 4'b1001, 1'b0, 1'b0);
    push_entry({o_and, c_al, 12'he43, 12'h000}, 64'h0, 4'b0001, 1'b0, 1'b0);
    push_entry({o_or, c_al, 12'he43, 12'h000}, 64'hFFFF_FFFF_FFFF_FFFF, 4'b0010, 1'b0, 1'b0);
    push_entry({o_xor, c_al, 12'hf30, 12'h0f0}, 64'h70F, 4'b0000, 1'b0, 1'b0);
    push_entry({o_shl, c_al, 12'h710, 12'h004}, 64'h50, 4'b0000, 1'b0, 1'b0);
    push_entry({o_shl, c_al, 12'ha21, 12'h000}, 64'hFFFF_FFFF_FFFF_FFE0, 4'b0010, 1'b0, 1'b0);
    push_entry({o_sar, c_al, 12'hc40, 12'h008}, 64'hFFFF_FFFF_FFFF_FFF8, 4'b0010, 1'b0, 1'b0);
    push_entry({o_sar, c_al, 12'hd81, 12'h000}, 64'h03FF_FFFF_FFFF_FFFF, 4'b0000, 1'b0, 1'b0);
    // skipped entries return the old rt value
    push_entry({o_sub, c_al, 12'h511, 12'h000}, 64'h0, 4'b1001, 1'b0, 1'b0);
    push_entry({o_add, c_ne, 12'h611, 12'h000}, 64'h804, 4'b1001, 1'b1, 1'b0);
    push_entry({o_add, c_eq, 12'h770, 12'h001}, 64'h51, 4'b0000, 1'b0, 1'b0);
    push_entry({o_movi, c_eq, 12'h300, 12'h123}, 64'h7FF, 4'b0000, 1'b1, 1'b0);
    push_entry({o_movi, c_lt, 12'h800, 12'h001}, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0000, 1'b1, 1'b0);
    push_entry({o_movi, c_ne, 12'ha00, 12'hfff}, 64'hFFFF_FFFF_FFFF_FFFF, 4'b0010, 1'b0, 1'b0);
    push_entry({o_movi, c_lt, 12'hb00, 12'h00a}, 64'hA, 4'b0000, 1'b0, 1'b0);
    push_entry({o_or, c_al, 12'hc35, 12'h000}, 64'h7FF, 4'b0000, 1'b0, 1'b0);
    push_entry({o_or, c_al, 12'he65, 12'h000}, 64'h804, 4'b0000, 1'b0, 1'b0);
    push_entry({o_add, c_al, 12'hd85, 12'h000}, 64'h7FFF_FFFF_FFFF_FFFF, 4'b0000, 1'b0, 1'b0);
    // mul and its dependents strobed back to back so the queue fills
    push_entry({o_mul, c_al, 12'h143, 12'h000}, 64'hFFFF_FFFF_FFC0_0800, 4'b0010, 1'b0, 1'b0);
    push_entry({o_add, c_al, 12'h210, 12'h100}, 64'hFFFF_FFFF_FFC0_0900, 4'b0010, 1'b0, 1'b1);
    push_entry({o_xor, c_al, 12'h521, 12'h000}, 64'h100, 4'b0000, 1'b0, 1'b1);
    push_entry({o_add, c_al, 12'h655, 12'h000}, 64'h200, 4'b0000, 1'b0, 1'b1);
    push_entry({o_mul, c_al, 12'h755, 12'h000}, 64'h10000, 4'b0000, 1'b0, 1'b1);
    push_entry({o_sub, c_al, 12'h876, 12'h000}, 64'hFE00, 4'b1000, 1'b0, 1'b1);
    push_entry({o_bad, c_al, 12'ha00, 12'h000}, 64'hFFFF_FFFF_FFFF_FFFF, 4'b1000, 1'b1, 1'b0);
  endtask

  task automatic drive_table();
    int idle;
    int waited;
    foreach (table_q[i]) begin
      if (!table_q[i].burst) begin
        idle = int'((next_random() >> 16) % 32'd4);
        repeat (idle) begin
          @(posedge clk);
          #1;
        end
      end
      waited = 0;
      while (busy) begin
        waited++;
        if (waited > busy_timeout) begin
          $display("timeout: busy stayed high before entry %0d", i);
          stop_with_failure();
        end
        @(posedge clk);
        #1;
      end
      instr_valid = 1'b1;
      instr       = table_q[i].word;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
  endtask

  task automatic collect_writebacks();
    int     waited;
    entry_t want;
    foreach (table_q[i]) begin
      want   = table_q[i];
      waited = 0;
      @(negedge clk);
      while (!wb_valid) begin
        waited++;
        if (waited > wb_timeout) begin
          $display("timeout: no writeback arrived for entry %0d", i);
          stop_with_failure();
        end
        @(negedge clk);
      end
      check_value(64'(wb.rt), 64'(want.word[23:20]), $sformatf("entry %0d rt", i));
      check_value(wb.data, want.data, $sformatf("entry %0d data", i));
      check_value(64'(wb.flags), 64'(want.flags), $sformatf("entry %0d flags", i));
      check_value(64'(wb.skipped), 64'(want.skipped), $sformatf("entry %0d skipped", i));
    end
  endtask

  initial begin
    int quiet;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    load_table();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      drive_table();
      collect_writebacks();
    join
    for (quiet = 0; quiet < quiet_cycles; quiet++) begin
      @(negedge clk);
      if (wb_valid) begin
        $display("unexpected writeback after the last instruction");
        stop_with_failure();
      end
    end
    check_value(64'(wb_count), 64'(table_q.size()), "writeback count");
    check_value(64'(busy_cycles != 0), 64'd1, "busy seen during multiply");
    check_value(64'(dut0.asrt0.fails), 64'd0, "assertion failures");
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: bench/exec_core_asserts.sv
/* protocol checks bound onto exec_core
   deq and head are internal exec_core wires, fails counts failed assertions */
`timescale 1ns/1ps

module exec_core_asserts (
  input logic           clk,
  input logic           rst,
  input logic           instr_valid,
  input logic           busy,
  input logic           deq,
  input core_pkg::uop_t head,
  input logic           wb_valid,
  input core_pkg::wb_t  wb
);

  int fails = 0;

  // a word strobed while busy can be dropped by the queue
  no_strobe_when_busy: assert property (
    @(posedge clk) disable iff (rst) instr_valid |-> !busy
  ) else begin
    fails++;
    $error("instr_valid strobed while busy is high");
  end

  no_wb_in_reset: assert property (@(posedge clk) rst |-> (wb_valid !== 1'b1)) else begin
    fails++;
    $error("wb_valid high during reset");
  end

  // non-mul ops write back one cycle after deq
  add_zero_flag: assert property (
    @(posedge clk) disable iff (rst)
    (deq && head.op == core_pkg::op_add) |=>
      (wb_valid && (wb.skipped || !(wb.flags.zero && wb.data != '0)))
  ) else begin
    fails++;
    $error("executed add shows zero flag with nonzero data");
  end

endmodule

// File: verilog/exec_core.sv
/* decoder -> queue -> execute, wiring only
   instr_valid must stay low while busy is high or the word is lost */
`timescale 1ns/1ps

module exec_core (
  input  logic          clk,
  input  logic          rst,
  input  logic          instr_valid,
  input  logic [31:0]   instr,
  output logic          busy,
  output logic          wb_valid,
  output core_pkg::wb_t wb
);

  logic           uop_valid;
  core_pkg::uop_t uop;
  logic           head_valid;
  core_pkg::uop_t head;
  logic           deq;

  uop_decoder dec0 (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .uop_valid   (uop_valid),
    .uop         (uop)
  );

  uop_queue que0 (
    .clk        (clk),
    .rst        (rst),
    .wr         (uop_valid),
    .wr_data    (uop),
    .deq        (deq),
    .head_valid (head_valid),
    .head       (head),
    .busy       (busy)
  );

  int_execute exe0 (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head       (head),
    .deq        (deq),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

endmodule

// File: execute/int_execute.sv
/* in-order execute: one uop per cycle, mul holds the unit for CORE_MUL_LAT cycles
   results are written one cycle after deq, no forwarding needed
   a false condition retires as skipped with the old rt value */
`timescale 1ns/1ps
`include "core_defs.svh"

module int_execute (
  input  logic           clk,
  input  logic           rst,
  input  logic           head_valid,
  input  core_pkg::uop_t head,
  output logic           deq,
  output logic           wb_valid,
  output core_pkg::wb_t  wb
);

  localparam int xlen  = `CORE_XLEN;
  localparam int cnt_w = $clog2(`CORE_MUL_LAT + 1);

  logic [xlen-1:0]    regs [`CORE_NREGS];
  core_pkg::flags_t   flags_q;
  logic               mul_busy;
  logic [cnt_w-1:0]   mul_cnt;
  core_pkg::reg_idx_t mul_rt;
  logic               mul_ok;
  logic [xlen-1:0]    prod_q;

  logic [xlen-1:0]    op_a;
  logic [xlen-1:0]    op_b;
  logic               is_mul;
  logic               cond_ok;
  core_pkg::op_e      alu_op;
  logic [xlen-1:0]    alu_b;
  logic [xlen-1:0]    alu_res;
  core_pkg::flags_t   alu_flags;
  logic               commit;
  core_pkg::reg_idx_t cm_rt;
  logic               cm_ok;

  function automatic logic cond_true(input logic [3:0] cond, input core_pkg::flags_t f);
    case (cond)
      4'd0:    cond_true = f.carry;
      4'd1:    cond_true = !f.carry;
      4'd2:    cond_true = f.carry ^ f.zero;
      4'd3:    cond_true = !(f.carry ^ f.zero);
      4'd4:    cond_true = f.overflow;
      4'd5:    cond_true = f.overflow || f.zero;
      4'd6:    cond_true = !f.overflow;
      4'd7:    cond_true = !f.overflow && !f.zero;
      4'd8:    cond_true = f.zero;
      4'd9:    cond_true = !f.zero;
      4'd10:   cond_true = f.negative;
      4'd11:   cond_true = 1'b1;
      4'd12:   cond_true = !f.negative;
      4'd13:   cond_true = !f.negative && !f.zero;
      4'd14:   cond_true = f.overflow ^ f.negative;
      default: cond_true = !(f.overflow ^ f.negative);
    endcase
  endfunction

  assign deq     = head_valid && !mul_busy;
  assign is_mul  = head.op == core_pkg::op_mul;
  assign op_a    = regs[head.ra];
  assign op_b    = head.use_imm ? head.imm : regs[head.rb];
  assign cond_ok = cond_true(head.cond, flags_q) && (head.op != core_pkg::op_nop);
  assign commit  = (deq && !is_mul) || (mul_busy && mul_cnt == cnt_w'(1));

  // while a mul is pending the alu just passes the product through for flags
  always_comb begin
    if (mul_busy) begin
      alu_op = core_pkg::op_movi;
      alu_b  = prod_q;
      cm_rt  = mul_rt;
      cm_ok  = mul_ok;
    end else begin
      alu_op = head.op;
      alu_b  = op_b;
      cm_rt  = head.rt;
      cm_ok  = cond_ok;
    end
  end

  int_alu alu0 (
    .op     (alu_op),
    .a      (op_a),
    .b      (alu_b),
    .result (alu_res),
    .flags  (alu_flags)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      mul_busy <= 1'b0;
      mul_cnt  <= '0;
      wb_valid <= 1'b0;
      flags_q  <= '0;
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
    end else begin
      wb_valid <= commit;
      if (deq && is_mul) begin
        mul_busy <= 1'b1;
        mul_cnt  <= cnt_w'(`CORE_MUL_LAT - 1);
      end else if (mul_busy) begin
        mul_cnt <= mul_cnt - 1'b1;
        if (mul_cnt == cnt_w'(1)) mul_busy <= 1'b0;
      end
      if (commit && cm_ok) begin
        regs[cm_rt] <= alu_res;
        flags_q     <= alu_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deq && is_mul) begin
      prod_q <= op_a * op_b; // low half only
      mul_rt <= head.rt;
      mul_ok <= cond_ok;
    end
    if (commit) begin
      wb.rt      <= cm_rt;
      wb.data    <= cm_ok ? alu_res : regs[cm_rt];
      wb.flags   <= cm_ok ? alu_flags : flags_q;
      wb.skipped <= !cm_ok;
    end
  end

endmodule

// File: execute/int_alu.sv
/* combinational integer datapath, everything except mul
   shift amount is b[5:0]; carry and overflow only come from add and sub */
`timescale 1ns/1ps
`include "core_defs.svh"

module int_alu (
  input  core_pkg::op_e        op,
  input  logic [`CORE_XLEN-1:0] a,
  input  logic [`CORE_XLEN-1:0] b,
  output logic [`CORE_XLEN-1:0] result,
  output core_pkg::flags_t      flags
);

  localparam int xlen = `CORE_XLEN;

  logic            is_sub;
  logic [xlen-1:0] b_eff;
  logic [xlen:0]   sum; // carry-out in the top bit
  logic [5:0]      shamt;
  logic            arith;

  // sub is a + ~b + 1, so carry means no borrow
  assign is_sub = op == core_pkg::op_sub;
  assign b_eff  = is_sub ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, is_sub};
  assign shamt  = b[5:0];
  assign arith  = (op == core_pkg::op_add) || is_sub;

  always_comb begin
    case (op)
      core_pkg::op_add,
      core_pkg::op_sub:  result = sum[xlen-1:0];
      core_pkg::op_and:  result = a & b;
      core_pkg::op_or:   result = a | b;
      core_pkg::op_xor:  result = a ^ b;
      core_pkg::op_shl:  result = a << shamt;
      core_pkg::op_shr:  result = a >> shamt;
      core_pkg::op_sar:  result = $signed(a) >>> shamt;
      core_pkg::op_movi: result = b; // also used to retire the mul product
      default:           result = '0;
    endcase
  end

  always_comb begin
    flags.negative = result[xlen-1];
    flags.zero     = result == '0;
    if (arith) begin
      flags.carry    = sum[xlen];
      // same operand signs, different result sign
      flags.overflow = (a[xlen-1] == b_eff[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    end else begin
      flags.carry    = 1'b0;
      flags.overflow = 1'b0;
    end
  end

endmodule

// File: verilog/uop_queue.sv
/* circular micro-op buffer, CORE_QDEPTH entries
   busy rises one entry early to leave room for the uop held in the decoder
   a write into a full queue without a deq is dropped */
`timescale 1ns/1ps
`include "core_defs.svh"

module uop_queue (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr,
  input  core_pkg::uop_t wr_data,
  input  logic           deq,
  output logic           head_valid,
  output core_pkg::uop_t head,
  output logic           busy
);

  localparam int depth = `CORE_QDEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  core_pkg::uop_t   mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full       = count == cnt_w'(depth);
  assign pop        = deq && head_valid;
  assign push       = wr && (!full || pop);
  assign head_valid = count != '0;
  assign head       = mem[rd_ptr];
  assign busy       = count >= cnt_w'(depth - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

endmodule

// File: verilog/uop_decoder.sv
/* one-cycle decode of a 32-bit instruction word into a micro-op
   illegal opcodes become op_nop, which execute always skips */
`timescale 1ns/1ps
`include "core_defs.svh"

module uop_decoder (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  output logic               uop_valid,
  output core_pkg::uop_t     uop
);

  logic [3:0]  opcode;
  logic [11:0] imm12;
  logic        legal;

  assign opcode = instr[31:28];
  assign imm12  = instr[11:0];
  assign legal  = opcode <= 4'd9;

  always_ff @(posedge clk) begin
    if (rst) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= instr_valid;
    end
  end

  // payload only, qualified by uop_valid
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      if (legal) begin
        uop.op <= core_pkg::op_e'(opcode);
      end else begin
        uop.op <= core_pkg::op_nop;
      end
      uop.cond <= instr[27:24];
      uop.rt   <= instr[23:20];
      uop.ra   <= instr[19:16];
      uop.rb   <= instr[15:12];
      uop.imm  <= {{(`CORE_XLEN - 12){imm12[11]}}, imm12};
      // movi always takes the immediate, others only when nonzero
      uop.use_imm <= (opcode == core_pkg::op_movi) || (imm12 != 12'd0);
    end
  end

endmodule

// File: common/core_pkg.sv
/* micro-op, flag and writeback types shared by the execute slice
   widths come from core_defs.svh */
`include "core_defs.svh"

package core_pkg;

  localparam int reg_w = $clog2(`CORE_NREGS);

  typedef logic [reg_w-1:0] reg_idx_t;
  typedef logic [`CORE_XLEN-1:0] word_t;

  // codes 10..14 never leave the decoder
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_shl  = 4'd5,
    op_shr  = 4'd6,
    op_sar  = 4'd7,
    op_movi = 4'd8,
    op_mul  = 4'd9,
    op_nop  = 4'd15 // illegal opcodes, always skipped
  } op_e;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

  typedef struct packed {
    op_e        op;
    logic [3:0] cond;
    reg_idx_t   rt;
    reg_idx_t   ra;
    reg_idx_t   rb;
    word_t      imm;     // already sign-extended
    logic       use_imm; // imm replaces rb
  } uop_t;

  typedef struct packed {
    reg_idx_t rt;
    word_t    data;
    flags_t   flags;
    logic     skipped;
  } wb_t;

endpackage

// File: common/core_defs.svh
/* core sizing macros, included by the package and by the RTL that needs widths
   CORE_MUL_LAT must be 2 or more, CORE_QDEPTH at least 2 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and register width
`define CORE_XLEN 64

// architectural registers, index width follows from this
`define CORE_NREGS 16

// micro-op queue entries
`define CORE_QDEPTH 4

// cycles from deq of a multiply to its writeback
`define CORE_MUL_LAT 3

`endif
